/* dv/rv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_checker #(
    parameter rv_core_pkg::word_t boot_pc    = '0,
    parameter int                 prog_words = 256
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  rv_core_pkg::word_t     imem_addr,
    input  wire logic              retire_valid,
    input  rv_core_pkg::word_t     retire_pc,
    input  rv_core_pkg::reg_addr_t retire_rd,
    input  rv_core_pkg::word_t     retire_data,
    input  rv_core_pkg::word_t     prog [prog_words],
    output logic                   done,
    output int                     error_count,
    output int                     retire_count
);

    localparam int iw = $clog2(prog_words);

    rv_core_pkg::word_t regs [32];
    rv_core_pkg::word_t dmem [1024];
    rv_core_pkg::word_t pc; // next pc the ISA model expects to retire
    rv_core_pkg::word_t addr_hist [3]; // imem_addr over the last three cycles
    logic bubble_due; // slot after a taken jump

    initial begin
        done         = 1'b0;
        error_count  = 0;
        retire_count = 0;
        pc           = boot_pc;
        bubble_due   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            addr_hist[i] = '0;
        end
    end

    // --------------------------------------------------
    // ISA reference
    function automatic logic signed_less(rv_core_pkg::word_t a, rv_core_pkg::word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b); // sign bits decide first
    endfunction

    function automatic rv_core_pkg::word_t alu_ref(rv_core_pkg::word_t a, rv_core_pkg::word_t b,
            logic [2:0] f3, logic alt);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, signed_less(a, b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(rv_core_pkg::word_t a, rv_core_pkg::word_t b,
            logic [2:0] f3);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return signed_less(a, b);
            3'd5: return !signed_less(a, b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare_field(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // --------------------------------------------------
    // sampled away from the rising edge
    always @(negedge clk) begin
        rv_core_pkg::word_t inst;
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t ea;
        rv_core_pkg::word_t result;
        rv_core_pkg::word_t next_pc;
        rv_core_pkg::word_t imm_i;
        rv_core_pkg::word_t imm_s;
        rv_core_pkg::word_t imm_b;
        rv_core_pkg::word_t imm_u;
        rv_core_pkg::word_t imm_j;
        logic writes;
        logic jumped;
        if (rst) begin
            if (retire_valid !== 1'b0) begin
                $display("retire_valid is not low during reset at %0t", $time);
                error_count++;
            end
        end else if (retire_valid === 1'b1) begin
            retire_count++;
            if (bubble_due) begin
                $display("unexpected retire at %0t of pc %h in the bubble after a taken jump",
                         $time, retire_pc);
                error_count++;
                bubble_due = 1'b0;
            end else begin
                inst    = prog[pc[iw+1:2]];
                a       = regs[inst[19:15]];
                b       = regs[inst[24:20]];
                imm_i   = {{20{inst[31]}}, inst[31:20]};
                imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                imm_u   = {inst[31:12], 12'd0};
                imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                next_pc = pc + 32'd4;
                result  = '0;
                writes  = 1'b1;
                jumped  = 1'b0;
                case (inst[6:0])
                    rv_core_pkg::opc_op: result = alu_ref(a, b, inst[14:12], inst[30]);
                    rv_core_pkg::opc_op_imm:
                        result = alu_ref(a, imm_i, inst[14:12], inst[14:12] == 3'd5 && inst[30]);
                    rv_core_pkg::opc_lui:   result = imm_u;
                    rv_core_pkg::opc_auipc: result = pc + imm_u;
                    rv_core_pkg::opc_jal: begin
                        result  = pc + 32'd4; // link
                        next_pc = pc + imm_j;
                        jumped  = 1'b1;
                    end
                    rv_core_pkg::opc_load: begin
                        ea     = a + imm_i;
                        result = dmem[ea[11:2]];
                    end
                    rv_core_pkg::opc_store: begin
                        ea             = a + imm_s;
                        dmem[ea[11:2]] = b;
                        writes         = 1'b0;
                    end
                    rv_core_pkg::opc_branch: begin
                        writes = 1'b0;
                        if (branch_ref(a, b, inst[14:12])) begin
                            next_pc = pc + imm_b;
                            jumped  = 1'b1;
                        end
                    end
                    default: begin
                        writes = 1'b0;
                        $display("model found an undefined instruction %h at pc %h", inst, pc);
                        error_count++;
                    end
                endcase
                if (inst[11:7] == 5'd0) begin
                    writes = 1'b0; // x0 stays zero
                end
                compare_field("imem_addr", addr_hist[2], pc); // shown three cycles earlier
                compare_field("retire_pc", retire_pc, pc);
                compare_field("retire_rd", {27'd0, retire_rd}, writes ? {27'd0, inst[11:7]} : '0);
                compare_field("retire_data", retire_data, writes ? result : '0);
                if (writes) begin
                    regs[inst[11:7]] = result;
                end
                bubble_due = jumped; // squashed instruction must not retire next cycle
                done = inst[6:0] == rv_core_pkg::opc_jal && imm_j == '0; // jump to itself
                pc   = next_pc;
            end
        end else begin
            bubble_due = 1'b0;
            if (retire_valid !== 1'b0) begin
                $display("retire_valid is unknown at %0t", $time);
                error_count++;
            end
        end
        addr_hist[2] = addr_hist[1];
        addr_hist[1] = addr_hist[0];
        addr_hist[0] = imem_addr;
    end

endmodule

`default_nettype wire

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int prog_words  = 256;
    localparam int cycle_limit = 4 * prog_words + 50;
    localparam rv_core_pkg::word_t boot_pc = '0;

    logic clk = 1'b0;
    logic rst;
    rv_core_pkg::word_t imem_addr;
    rv_core_pkg::word_t imem_data;
    logic retire_valid;
    rv_core_pkg::word_t retire_pc;
    rv_core_pkg::reg_addr_t retire_rd;
    rv_core_pkg::word_t retire_data;

    rv_core_pkg::word_t prog [prog_words];
    integer seed;
    int cycles;
    logic done;
    int error_count;
    int retire_count;

    // --------------------------------------------------
    // instruction encoders
    function automatic rv_core_pkg::word_t r_format(logic [6:0] f7, rv_core_pkg::reg_addr_t rs2,
            rv_core_pkg::reg_addr_t rs1, logic [2:0] f3, rv_core_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::opc_op};
    endfunction

    function automatic rv_core_pkg::word_t i_format(logic [11:0] imm, rv_core_pkg::reg_addr_t rs1,
            logic [2:0] f3, rv_core_pkg::reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t s_format(logic [11:0] imm, rv_core_pkg::reg_addr_t rs2,
            rv_core_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::opc_store}; // sw
    endfunction

    function automatic rv_core_pkg::word_t b_format(logic [12:0] off, rv_core_pkg::reg_addr_t rs2,
            rv_core_pkg::reg_addr_t rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::opc_branch};
    endfunction

    function automatic rv_core_pkg::word_t u_format(logic [19:0] imm, rv_core_pkg::reg_addr_t rd,
            logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t j_format(logic [20:0] off, rv_core_pkg::reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::opc_jal};
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // x7 holds the data base and is never a destination
    task automatic build_program();
        int kind;
        int k;
        int b;
        logic alt;
        logic [2:0] f3;
        logic [11:0] imm12;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::reg_addr_t rs1;
        rv_core_pkg::reg_addr_t rs2;
        prog[0] = i_format(12'h100, 5'd0, 3'b000, 5'd7, rv_core_pkg::opc_op_imm);
        for (int w = 0; w < 8; w++) begin
            prog[1 + w] = s_format(12'(4 * w), 5'd0, 5'd7); // clear the data window
        end
        for (int i = 9; i < prog_words - 1; i++) begin
            rd   = 5'(rand_below(7));
            rs1  = 5'(rand_below(8));
            rs2  = 5'(rand_below(8));
            f3   = 3'(rand_below(8));
            alt  = (f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1;
            k    = 1 + rand_below(4);
            kind = rand_below(12);
            if (i + k > prog_words - 1) begin
                k = prog_words - 1 - i; // forward only, never past the last word
            end
            case (kind)
                0, 1, 2: prog[i] = r_format({1'b0, alt, 5'd0}, rs2, rs1, f3, rd);
                3, 4, 5: begin
                    imm12 = 12'(rand_below(4096));
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm12 = {1'b0, alt, 5'd0, imm12[4:0]}; // shamt, bit 30 for srai
                    end
                    prog[i] = i_format(imm12, rs1, f3, rd, rv_core_pkg::opc_op_imm);
                end
                6: prog[i] = u_format(20'(rand_below(1 << 20)), rd, rv_core_pkg::opc_lui);
                7: prog[i] = u_format(20'(rand_below(1 << 20)), rd, rv_core_pkg::opc_auipc);
                8: prog[i] = i_format(12'(4 * rand_below(8)), 5'd7, 3'b010, rd,
                                      rv_core_pkg::opc_load);
                9: prog[i] = s_format(12'(4 * rand_below(8)), rs2, 5'd7);
                10: begin
                    b  = rand_below(6);
                    f3 = (b < 2) ? 3'(b) : 3'(b + 2); // skip the two unused codes
                    prog[i] = b_format(13'(4 * k), rs2, rs1, f3);
                end
                default: prog[i] = j_format(21'(4 * k), rd);
            endcase
        end
        prog[prog_words - 1] = j_format(21'd0, 5'd0); // park here
    endtask

    // 256 words, so anything at or above 1024 is past the end
    function automatic rv_core_pkg::word_t fetch_word(rv_core_pkg::word_t addr);
        if (addr[31:10] != '0) begin
            return rv_core_pkg::nop_inst;
        end
        return prog[addr[9:2]];
    endfunction

    // --------------------------------------------------
    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        imem_data <= fetch_word(imem_addr); // synchronous RAM, one cycle
    end

    rv_core_top #(
        .boot_pc(boot_pc),
        .dmem_words(1024)
    ) rv_core_top_i (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    rv_checker #(
        .boot_pc(boot_pc),
        .prog_words(prog_words)
    ) rv_checker_i (
        .clk(clk), .rst(rst), .imem_addr(imem_addr),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data),
        .prog(prog), .done(done),
        .error_count(error_count), .retire_count(retire_count)
    );

    initial begin
        seed      = 9;
        rst       = 1'b1;
        imem_data = rv_core_pkg::nop_inst;
        cycles    = 0;
        build_program();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (!done && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("errors %0d, retired %0d", error_count, retire_count);
        if (!done) begin
            $display("timeout after %0d cycles without reaching the final jal", cycles);
        end
        if (done && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_core_pkg::word_t a,
    input  rv_core_pkg::word_t b,
    input  wire logic [2:0]    funct3,
    input  wire logic          alt,
    output rv_core_pkg::word_t result
);

    logic [4:0] shamt;
    rv_core_pkg::word_t sra_result; // arithmetic shift, sign filled from a[31]

    assign shamt      = b[4:0];
    assign sra_result = $signed(a) >>> shamt;

    always_comb begin
        case (funct3)
            rv_core_pkg::f3_add_sub: result = alt ? a - b : a + b;
            rv_core_pkg::f3_sll:     result = a << shamt;
            rv_core_pkg::f3_slt:     result = {31'd0, $signed(a) < $signed(b)};
            rv_core_pkg::f3_sltu:    result = {31'd0, a < b};
            rv_core_pkg::f3_xor:     result = a ^ b;
            rv_core_pkg::f3_srl_sra: result = alt ? sra_result : a >> shamt;
            rv_core_pkg::f3_or:      result = a | b;
            default:                 result = a & b; // and
        endcase
    end

endmodule

`default_nettype wire

/* logic/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  rv_core_pkg::word_t       ex_inst,
    input  wire logic                branch_taken,
    input  rv_core_pkg::reg_addr_t   mwb_rd,
    input  wire logic                mwb_reg_we,
    output rv_core_pkg::word_t       imm,
    output rv_core_pkg::alu_a_sel_e  alu_a_sel,
    output rv_core_pkg::alu_b_sel_e  alu_b_sel,
    output logic [2:0]               alu_funct3,
    output logic                     alu_alt,
    output rv_core_pkg::wb_sel_e     wb_sel,
    output logic                     reg_we,
    output logic                     mem_we,
    output rv_core_pkg::fwd_sel_e    fwd_rs1,
    output rv_core_pkg::fwd_sel_e    fwd_rs2,
    output logic                     flush
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    logic writes_rd;

    assign opcode = ex_inst[6:0];
    assign funct3 = ex_inst[14:12];
    assign rd     = ex_inst[11:7];
    assign rs1    = ex_inst[19:15];
    assign rs2    = ex_inst[24:20];

    // --------------------------------------------------
    // immediate formats
    always_comb begin
        case (opcode)
            rv_core_pkg::opc_store:
                imm = {{20{ex_inst[31]}}, ex_inst[31:25], ex_inst[11:7]};
            rv_core_pkg::opc_branch:
                imm = {{19{ex_inst[31]}}, ex_inst[31], ex_inst[7], ex_inst[30:25],
                       ex_inst[11:8], 1'b0};
            rv_core_pkg::opc_lui, rv_core_pkg::opc_auipc:
                imm = {ex_inst[31:12], 12'd0};
            rv_core_pkg::opc_jal:
                imm = {{11{ex_inst[31]}}, ex_inst[31], ex_inst[19:12], ex_inst[20],
                       ex_inst[30:21], 1'b0};
            default:
                imm = {{20{ex_inst[31]}}, ex_inst[31:20]}; // I format
        endcase
    end

    // --------------------------------------------------
    // selects and enables, all zero for a bubble
    always_comb begin
        alu_a_sel  = rv_core_pkg::alu_a_rs1;
        alu_b_sel  = rv_core_pkg::alu_b_imm;
        alu_funct3 = rv_core_pkg::f3_add_sub;
        alu_alt    = 1'b0;
        wb_sel     = rv_core_pkg::wb_alu;
        writes_rd  = 1'b0;
        mem_we     = 1'b0;
        flush      = 1'b0;
        case (opcode)
            rv_core_pkg::opc_op: begin
                alu_b_sel  = rv_core_pkg::alu_b_rs2;
                alu_funct3 = funct3;
                alu_alt    = ex_inst[30];
                writes_rd  = 1'b1;
            end
            rv_core_pkg::opc_op_imm: begin
                alu_funct3 = funct3;
                alu_alt    = (funct3 == rv_core_pkg::f3_srl_sra) && ex_inst[30]; // srai only
                writes_rd  = 1'b1;
            end
            rv_core_pkg::opc_lui: begin
                wb_sel    = rv_core_pkg::wb_imm;
                writes_rd = 1'b1;
            end
            rv_core_pkg::opc_auipc: begin
                alu_a_sel = rv_core_pkg::alu_a_pc;
                writes_rd = 1'b1;
            end
            rv_core_pkg::opc_jal: begin
                wb_sel    = rv_core_pkg::wb_pc4; // link
                writes_rd = 1'b1;
                flush     = 1'b1;
            end
            rv_core_pkg::opc_branch: flush = branch_taken;
            rv_core_pkg::opc_load: begin
                wb_sel    = rv_core_pkg::wb_mem;
                writes_rd = 1'b1;
            end
            rv_core_pkg::opc_store: mem_we = 1'b1;
            default: ;
        endcase
    end

    assign reg_we = writes_rd && (rd != 5'd0); // x0 writes dropped here

    // forward from memory/writeback when it targets our source
    assign fwd_rs1 = (mwb_reg_we && mwb_rd != 5'd0 && mwb_rd == rs1) ?
                     rv_core_pkg::fwd_mwb : rv_core_pkg::fwd_regfile;
    assign fwd_rs2 = (mwb_reg_we && mwb_rd != 5'd0 && mwb_rd == rs2) ?
                     rv_core_pkg::fwd_mwb : rv_core_pkg::fwd_regfile;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  rv_core_pkg::word_t      fd_inst,
    input  rv_core_pkg::word_t      fd_pc,
    input  rv_core_pkg::word_t      rs1_val,
    input  rv_core_pkg::word_t      rs2_val,
    input  wire logic               flush,
    output rv_core_pkg::word_t      ex_inst,
    input  rv_core_pkg::word_t      imm,
    input  rv_core_pkg::alu_a_sel_e alu_a_sel,
    input  rv_core_pkg::alu_b_sel_e alu_b_sel,
    input  wire logic [2:0]         alu_funct3,
    input  wire logic               alu_alt,
    input  rv_core_pkg::fwd_sel_e   fwd_rs1,
    input  rv_core_pkg::fwd_sel_e   fwd_rs2,
    input  rv_core_pkg::word_t      mwb_wb_data,
    output rv_core_pkg::word_t      ex_result,
    output rv_core_pkg::word_t      ex_store_data,
    output rv_core_pkg::word_t      ex_pc,
    output logic                    branch_taken,
    output rv_core_pkg::word_t      redirect_pc
);

    rv_core_pkg::word_t inst_q;
    rv_core_pkg::word_t pc_q;
    rv_core_pkg::word_t rs1_q;
    rv_core_pkg::word_t rs2_q;
    rv_core_pkg::word_t op1;
    rv_core_pkg::word_t op2;
    rv_core_pkg::word_t alu_a;
    rv_core_pkg::word_t alu_b;

    // --------------------------------------------------
    // fetch/decode -> execute
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_q <= rv_core_pkg::nop_inst;
        end else begin
            inst_q <= flush ? rv_core_pkg::nop_inst : fd_inst;
        end
    end

    always_ff @(posedge clk) begin
        pc_q  <= fd_pc;
        rs1_q <= rs1_val;
        rs2_q <= rs2_val;
    end

    // forwarding, then operand muxes
    assign op1   = (fwd_rs1 == rv_core_pkg::fwd_mwb) ? mwb_wb_data : rs1_q;
    assign op2   = (fwd_rs2 == rv_core_pkg::fwd_mwb) ? mwb_wb_data : rs2_q;
    assign alu_a = (alu_a_sel == rv_core_pkg::alu_a_pc) ? pc_q : op1;
    assign alu_b = (alu_b_sel == rv_core_pkg::alu_b_imm) ? imm : op2;

    alu alu_i (
        .a(alu_a),
        .b(alu_b),
        .funct3(alu_funct3),
        .alt(alu_alt),
        .result(ex_result)
    );

    // --------------------------------------------------
    // branch compare, only meaningful for branch opcodes
    always_comb begin
        case (inst_q[14:12])
            rv_core_pkg::f3_beq:  branch_taken = op1 == op2;
            rv_core_pkg::f3_bne:  branch_taken = op1 != op2;
            rv_core_pkg::f3_blt:  branch_taken = $signed(op1) < $signed(op2);
            rv_core_pkg::f3_bge:  branch_taken = $signed(op1) >= $signed(op2);
            rv_core_pkg::f3_bltu: branch_taken = op1 < op2;
            rv_core_pkg::f3_bgeu: branch_taken = op1 >= op2;
            default:              branch_taken = 1'b0;
        endcase
    end

    assign redirect_pc   = pc_q + imm; // branch and jal target
    assign ex_inst       = inst_q;
    assign ex_pc         = pc_q;
    assign ex_store_data = op2;

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_core_pkg::word_t boot_pc = '0
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  rv_core_pkg::word_t redirect_pc,
    output rv_core_pkg::word_t imem_addr,
    input  rv_core_pkg::word_t imem_data,
    output rv_core_pkg::word_t fd_inst,
    output rv_core_pkg::word_t fd_pc
);

    rv_core_pkg::word_t pc_q;    // address on the instruction port
    rv_core_pkg::word_t fd_pc_q; // address of the word now returning
    logic kill_q;

    // --------------------------------------------------
    // fetch address
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q   <= boot_pc;
            kill_q <= 1'b1; // nothing valid returns in the first cycle
        end else begin
            pc_q   <= flush ? redirect_pc : pc_q + 32'd4;
            kill_q <= flush; // word fetched during the redirect is wrong path
        end
    end

    always_ff @(posedge clk) begin
        fd_pc_q <= pc_q;
    end

    assign imem_addr = pc_q;
    assign fd_pc     = fd_pc_q;

    // squash into a bubble
    assign fd_inst = (flush || kill_q) ? rv_core_pkg::nop_inst : imem_data;

endmodule

`default_nettype wire

/* logic/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
    parameter int dmem_words = 1024
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  rv_core_pkg::word_t     ex_result,
    input  rv_core_pkg::word_t     ex_store_data,
    input  rv_core_pkg::word_t     ex_pc,
    input  rv_core_pkg::reg_addr_t ex_rd,
    input  rv_core_pkg::word_t     imm,
    input  rv_core_pkg::wb_sel_e   wb_sel,
    input  wire logic              reg_we,
    input  wire logic              mem_we,
    input  wire logic              ex_valid,
    output rv_core_pkg::reg_addr_t mwb_rd,
    output logic                   mwb_reg_we,
    output rv_core_pkg::word_t     mwb_wb_data,
    output logic                   retire_valid,
    output rv_core_pkg::word_t     retire_pc,
    output rv_core_pkg::reg_addr_t retire_rd,
    output rv_core_pkg::word_t     retire_data
);

    localparam int aw = $clog2(dmem_words);

    rv_core_pkg::word_t ram [dmem_words];
    rv_core_pkg::word_t ram_rdata;
    logic [aw-1:0] ram_idx;

    rv_core_pkg::word_t result_q;
    rv_core_pkg::word_t pc_q;
    rv_core_pkg::word_t imm_q;
    rv_core_pkg::reg_addr_t rd_q;
    rv_core_pkg::wb_sel_e wb_sel_q;
    logic reg_we_q;
    logic valid_q;

    // --------------------------------------------------
    // data RAM, word addressed
    assign ram_idx = ex_result[aw+1:2];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            ram[ram_idx] <= ex_store_data;
        end
        ram_rdata <= ram[ram_idx]; // lands with the retire cycle
    end

    // execute -> memory/writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_we_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            reg_we_q <= reg_we;
            valid_q  <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        result_q <= ex_result;
        pc_q     <= ex_pc;
        imm_q    <= imm;
        rd_q     <= ex_rd;
        wb_sel_q <= wb_sel;
    end

    always_comb begin
        case (wb_sel_q)
            rv_core_pkg::wb_mem: mwb_wb_data = ram_rdata;
            rv_core_pkg::wb_pc4: mwb_wb_data = pc_q + 32'd4;
            rv_core_pkg::wb_imm: mwb_wb_data = imm_q;
            default:             mwb_wb_data = result_q;
        endcase
    end

    assign mwb_rd     = rd_q;
    assign mwb_reg_we = reg_we_q;

    // stores and branches report no register write
    assign retire_valid = valid_q;
    assign retire_pc    = pc_q;
    assign retire_rd    = reg_we_q ? rd_q : 5'd0;
    assign retire_data  = reg_we_q ? mwb_wb_data : '0;

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire logic              rst,
    input  rv_core_pkg::reg_addr_t ra1,
    input  rv_core_pkg::reg_addr_t ra2,
    output rv_core_pkg::word_t     rd1,
    output rv_core_pkg::word_t     rd2,
    input  rv_core_pkg::reg_addr_t wa,
    input  rv_core_pkg::word_t     wd,
    input  wire logic              we
);

    rv_core_pkg::word_t regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write passes straight through
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* logic/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // --------------------------------------------------
    // opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // --------------------------------------------------
    // datapath selects
    typedef enum logic {alu_a_rs1, alu_a_pc} alu_a_sel_e;
    typedef enum logic {alu_b_rs2, alu_b_imm} alu_b_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_imm} wb_sel_e;
    typedef enum logic {fwd_regfile, fwd_mwb} fwd_sel_e;

    localparam word_t nop_inst = '0; // bubble, never retires

endpackage

`default_nettype wire

/* logic/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_core_pkg::word_t boot_pc    = '0,
    parameter int                 dmem_words = 1024
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    output rv_core_pkg::word_t          imem_addr,
    input  rv_core_pkg::word_t          imem_data,
    output logic                        retire_valid,
    output rv_core_pkg::word_t          retire_pc,
    output rv_core_pkg::reg_addr_t      retire_rd,
    output rv_core_pkg::word_t          retire_data
);

    // fetch/decode
    rv_core_pkg::word_t fd_inst;
    rv_core_pkg::word_t fd_pc;
    rv_core_pkg::word_t rs1_val;
    rv_core_pkg::word_t rs2_val;

    // execute
    rv_core_pkg::word_t ex_inst;
    rv_core_pkg::word_t ex_result;
    rv_core_pkg::word_t ex_store_data;
    rv_core_pkg::word_t ex_pc;
    rv_core_pkg::word_t imm;
    rv_core_pkg::word_t redirect_pc;
    rv_core_pkg::reg_addr_t ex_rd;
    rv_core_pkg::alu_a_sel_e alu_a_sel;
    rv_core_pkg::alu_b_sel_e alu_b_sel;
    rv_core_pkg::wb_sel_e wb_sel;
    rv_core_pkg::fwd_sel_e fwd_rs1;
    rv_core_pkg::fwd_sel_e fwd_rs2;
    logic [2:0] alu_funct3;
    logic alu_alt;
    logic reg_we;
    logic mem_we;
    logic branch_taken;
    logic flush;
    logic ex_valid;

    // memory/writeback
    rv_core_pkg::reg_addr_t mwb_rd;
    rv_core_pkg::word_t mwb_wb_data;
    logic mwb_reg_we;

    assign ex_rd    = ex_inst[11:7];
    assign ex_valid = ex_inst != rv_core_pkg::nop_inst; // bubbles carry an all-zero word

    fetch_unit #(
        .boot_pc(boot_pc)
    ) fetch_unit_i (
        .clk(clk), .rst(rst), .flush(flush), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .fd_inst(fd_inst), .fd_pc(fd_pc)
    );

    reg_file reg_file_i (
        .clk(clk), .rst(rst),
        .ra1(fd_inst[19:15]), .ra2(fd_inst[24:20]),
        .rd1(rs1_val), .rd2(rs2_val),
        .wa(mwb_rd), .wd(mwb_wb_data), .we(mwb_reg_we)
    );

    control_unit control_unit_i (
        .ex_inst(ex_inst), .branch_taken(branch_taken),
        .mwb_rd(mwb_rd), .mwb_reg_we(mwb_reg_we),
        .imm(imm), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
        .alu_funct3(alu_funct3), .alu_alt(alu_alt), .wb_sel(wb_sel),
        .reg_we(reg_we), .mem_we(mem_we),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .flush(flush)
    );

    execute_stage execute_stage_i (
        .clk(clk), .rst(rst),
        .fd_inst(fd_inst), .fd_pc(fd_pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .flush(flush), .ex_inst(ex_inst),
        .imm(imm), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
        .alu_funct3(alu_funct3), .alu_alt(alu_alt),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .mwb_wb_data(mwb_wb_data),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_pc(ex_pc),
        .branch_taken(branch_taken), .redirect_pc(redirect_pc)
    );

    mem_wb_stage #(
        .dmem_words(dmem_words)
    ) mem_wb_stage_i (
        .clk(clk), .rst(rst),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_pc(ex_pc),
        .ex_rd(ex_rd), .imm(imm), .wb_sel(wb_sel),
        .reg_we(reg_we), .mem_we(mem_we), .ex_valid(ex_valid),
        .mwb_rd(mwb_rd), .mwb_reg_we(mwb_reg_we), .mwb_wb_data(mwb_wb_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core_top.f --top-module tb_rv_core -o sim_tb \
    > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "^SIMULATION PASSED$" sim.log && exit 0 || exit 1

/* rv_core_top.f */
logic/rv_core_pkg.sv
logic/alu.sv
logic/fetch_unit.sv
logic/control_unit.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core_top.sv
dv/rv_checker.sv
dv/tb_rv_core.sv
